//--- files.f
+incdir+.
fma_pkg.sv
fma_csr.sv
fma_unpack.sv
fma_mul_align.sv
fma_add_norm.sv
fma_round_pack.sv
fma_top.sv
tb_fma.sv

//--- Makefile
# Verilator build and run of the FMA testbench

VERILATOR ?= verilator
TOP       ?= tb_fma
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_fma.sv
// ==========================================================
// FMA testbench
// ==========================================================
`default_nettype none
`include "fma_defs.svh"

module tb_fma
  import fma_pkg::*;
();

  localparam int NUM_VECS = 20;

  // Flag patterns, order is {nv, of, uf, nx}
  localparam fp_flags_t flag_none = 4'b0000;
  localparam fp_flags_t flag_nv   = 4'b1000;
  localparam fp_flags_t flag_nx   = 4'b0001;
  localparam fp_flags_t flag_ofnx = 4'b0101;
  localparam fp_flags_t flag_ufnx = 4'b0011;

  // One table row
  typedef struct packed {
    fma_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] res;
    fp_flags_t   flags;
  } vec_t;

  // Operation in flight, due is the cycle its result must appear
  typedef struct packed {
    logic [31:0] idx;
    logic [31:0] due;
  } pending_t;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  logic [31:0] i_a;
  logic [31:0] i_b;
  logic [31:0] i_c;
  apb_req_t    i_apb;
  logic [31:0] o_prdata;
  logic        o_valid;
  logic [31:0] o_result;
  fp_flags_t   o_flags;

  vec_t        vecs[NUM_VECS];
  string       names[NUM_VECS];
  int          num_loaded = 0;
  int          num_checked = 0;
  int unsigned cyc = 0;
  pending_t    pending[$];
  pending_t    head;
  fp_flags_t   flags_or;
  fp_flags_t   nv_only;
  int unsigned seed_dummy;

  fma_top dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (i_valid),
    .i_a      (i_a),
    .i_b      (i_b),
    .i_c      (i_c),
    .i_apb    (i_apb),
    .o_prdata (o_prdata),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_flags  (o_flags)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Rising edges since time zero
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  // ==========================================================
  // Reporting
  // ==========================================================
  task automatic show_mismatch(input string test, input string what,
                               input logic [31:0] expv, input logic [31:0] actv);
    $display("CHECK FAILED %s %s: expected %h, actual %h", test, what, expv, actv);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic stop_on_error(input string msg);
    $display("ERROR %s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // ==========================================================
  // Test table
  // ==========================================================
  task automatic add_vec(input string name, input fma_op_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] c,
                         input logic [31:0] res, input fp_flags_t flags);
    vecs[num_loaded]  = '{op: op, a: a, b: b, c: c, res: res, flags: flags};
    names[num_loaded] = name;
    num_loaded++;
  endtask

  // Rows of one variant stay together, at least two per group
  task automatic load_table();
    // 3 x 4 + 2 = 14
    add_vec("add_int",       FMADD,  32'h4040_0000, 32'h4080_0000, 32'h4000_0000,
            32'h4160_0000, flag_none);
    // (1+2^-23)^2 = 1 + 2^-22 + 2^-46, low part below half an ulp
    add_vec("round_up",      FMADD,  32'h3F80_0001, 32'h3F80_0001, 32'h0000_0000,
            32'h3F80_0002, flag_nx);
    // 1.5 x (1+2^-23), exact half ulp above an odd mantissa
    add_vec("tie_even",      FMADD,  32'h3F80_0001, 32'h3FC0_0000, 32'h0000_0000,
            32'h3FC0_0002, flag_nx);
    // 1.5 x (1+3*2^-23), half ulp above an even mantissa
    add_vec("tie_down",      FMADD,  32'h3F80_0003, 32'h3FC0_0000, 32'h0000_0000,
            32'h3FC0_0004, flag_nx);
    add_vec("qnan",          FMADD,  32'h7FC1_2345, 32'h3F80_0000, 32'h3F80_0000,
            `FMA_CANON_NAN, flag_none);
    add_vec("snan",          FMADD,  32'h3F80_0000, 32'h7F80_0001, 32'h3F80_0000,
            `FMA_CANON_NAN, flag_nv);
    add_vec("inf_x_zero",    FMADD,  32'h7F80_0000, 32'h0000_0000, 32'h3F80_0000,
            `FMA_CANON_NAN, flag_nv);
    add_vec("inf_minus_inf", FMADD,  32'h7F80_0000, 32'h3F80_0000, 32'hFF80_0000,
            `FMA_CANON_NAN, flag_nv);
    add_vec("inf_plus_fin",  FMADD,  32'hFF80_0000, 32'h4000_0000, 32'h3F80_0000,
            32'hFF80_0000, flag_none);
    // 2^127 squared
    add_vec("overflow",      FMADD,  32'h7F00_0000, 32'h7F00_0000, 32'h0000_0000,
            32'h7F80_0000, flag_ofnx);
    // -2^-126 x 0.5 lands below the normal range
    add_vec("underflow",     FMADD,  32'h8080_0000, 32'h3F00_0000, 32'h0000_0000,
            32'h8000_0000, flag_ufnx);
    // Subnormal counts as zero, so inf x subnormal is invalid
    add_vec("sub_as_zero",   FMADD,  32'h7F80_0000, 32'h0040_0000, 32'h3F80_0000,
            `FMA_CANON_NAN, flag_nv);
    // 2 x 3 plus a subnormal addend is exactly 6
    add_vec("sub_addend",    FMADD,  32'h4000_0000, 32'h4040_0000, 32'h0040_0000,
            32'h40C0_0000, flag_none);
    // Subnormal x 2 vanishes, only the addend 1.0 is left
    add_vec("sub_factor",    FMADD,  32'h0040_0000, 32'h4000_0000, 32'h3F80_0000,
            32'h3F80_0000, flag_none);
    add_vec("fmsub_int",     FMSUB,  32'h4040_0000, 32'h4080_0000, 32'h4000_0000,
            32'h4120_0000, flag_none);
    // 2 x 3 - 6 cancels to +0
    add_vec("fmsub_cancel",  FMSUB,  32'h4000_0000, 32'h4040_0000, 32'h40C0_0000,
            32'h0000_0000, flag_none);
    add_vec("fnmadd_int",    FNMADD, 32'h4040_0000, 32'h4080_0000, 32'h4000_0000,
            32'hC160_0000, flag_none);
    add_vec("fnmadd_inf",    FNMADD, 32'h7F80_0000, 32'h3F80_0000, 32'h3F80_0000,
            32'hFF80_0000, flag_none);
    add_vec("fnmsub_int",    FNMSUB, 32'h4040_0000, 32'h4080_0000, 32'h4000_0000,
            32'hC120_0000, flag_none);
    // -(1.5 x 2) + 0.5 = -2.5
    add_vec("fnmsub_frac",   FNMSUB, 32'h3FC0_0000, 32'h4000_0000, 32'h3F00_0000,
            32'hC020_0000, flag_none);
  endtask

  // ==========================================================
  // APB access, called right after a falling edge
  // ==========================================================
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    i_apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(negedge i_clk);
    i_apb.penable = 1'b1;
    @(negedge i_clk);
    i_apb = '0;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    i_apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
    @(negedge i_clk);
    i_apb.penable = 1'b1;
    // Read data settles within the access phase
    #1;
    data = o_prdata;
    @(negedge i_clk);
    i_apb = '0;
  endtask

  task automatic check_reg(input string test, input logic [3:0] addr,
                           input logic [31:0] expv);
    logic [31:0] actv;
    read_reg(addr, actv);
    assert (actv == expv) else show_mismatch(test, "register", expv, actv);
  endtask

  // ==========================================================
  // Operand stream
  // ==========================================================
  // Each CTRL change has its access phase in the cycle before the
  // first operand of the new variant, setup one cycle earlier
  task automatic run_stream(input bit with_gaps);
    int issue[NUM_VECS];
    int t;
    int last;
    t = 0;
    for (int i = 0; i < NUM_VECS; i++) begin
      issue[i] = t;
      t = t + 1 + (with_gaps ? int'($urandom % 4) : 0);
    end
    last = issue[NUM_VECS-1];
    write_reg(`FMA_ADDR_CTRL, {30'd0, vecs[0].op});
    for (int k = 0; k <= last; k++) begin
      i_valid = 1'b0;
      i_apb   = '0;
      for (int i = 0; i < NUM_VECS; i++) begin
        if (issue[i] == k) begin
          i_valid = 1'b1;
          i_a     = vecs[i].a;
          i_b     = vecs[i].b;
          i_c     = vecs[i].c;
          pending.push_back('{idx: i, due: cyc + `FMA_LATENCY});
        end
        if (i > 0 && vecs[i].op != vecs[i-1].op) begin
          if (issue[i] - 1 == k) begin
            i_apb = '{psel: 1'b1, penable: 1'b1, pwrite: 1'b1,
                      paddr: `FMA_ADDR_CTRL, pwdata: {30'd0, vecs[i].op}};
          end else if (issue[i] - 2 == k) begin
            i_apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1,
                      paddr: `FMA_ADDR_CTRL, pwdata: {30'd0, vecs[i].op}};
          end
        end
      end
      @(negedge i_clk);
    end
    i_valid = 1'b0;
    i_apb   = '0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending.size() > 0 && n < 4 * `FMA_LATENCY) begin
      @(negedge i_clk);
      n++;
    end
    assert (pending.size() == 0) else
      stop_on_error("timeout, results stopped coming out with operations still in flight");
  endtask

  // ==========================================================
  // Output monitor, outputs are stable at the falling edge
  // ==========================================================
  always @(negedge i_clk) begin
    if (o_valid) begin
      assert (pending.size() > 0) else
        stop_on_error("a result came out with no operation in flight");
      head = pending.pop_front();
      assert (head.due == cyc) else
        show_mismatch(names[head.idx], "output cycle", head.due, cyc);
      assert (o_result == vecs[head.idx].res) else
        show_mismatch(names[head.idx], "result", vecs[head.idx].res, o_result);
      assert (o_flags == vecs[head.idx].flags) else
        show_mismatch(names[head.idx], "flags", {28'd0, vecs[head.idx].flags},
                      {28'd0, o_flags});
      num_checked++;
    end else if (pending.size() > 0) begin
      assert (pending[0].due != cyc) else
        stop_on_error($sformatf("no result for %s at its due cycle",
                                names[pending[0].idx]));
    end
  end

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    i_rst      = 1'b1;
    i_valid    = 1'b0;
    i_a        = 32'd0;
    i_b        = 32'd0;
    i_c        = 32'd0;
    i_apb      = '0;
    seed_dummy = $urandom(32'h369b_d296);
    load_table();
    flags_or = '0;
    for (int i = 0; i < NUM_VECS; i++) begin
      flags_or = flags_or | vecs[i].flags;
    end

    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;

    check_reg("flags_reset", `FMA_ADDR_FLAGS, 32'd0);
    check_reg("ctrl_reset", `FMA_ADDR_CTRL, {30'd0, FMADD});

    // Back to back, then with random idle cycles
    run_stream(1'b0);
    wait_drain();
    run_stream(1'b1);
    wait_drain();

    check_reg("ctrl_last", `FMA_ADDR_CTRL, {30'd0, FNMSUB});
    check_reg("unmapped", 4'h8, 32'd0);
    check_reg("flags_sticky", `FMA_ADDR_FLAGS, {28'd0, flags_or});
    // Clear nv alone, the rest stays
    nv_only    = '0;
    nv_only.nv = 1'b1;
    write_reg(`FMA_ADDR_FLAGS, {28'd0, nv_only});
    check_reg("flags_clear_nv", `FMA_ADDR_FLAGS, {28'd0, flags_or & ~nv_only});

    if (num_checked == 2 * NUM_VECS) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("checked %0d results instead of %0d",
                              num_checked, 2 * NUM_VECS));
    end
  end

endmodule

`default_nettype wire

//--- fma_top.sv
// ==========================================================
// FMA top level
// ==========================================================
`default_nettype none

module fma_top
  import fma_pkg::*;
(
  input  wire logic        i_clk,
  input  wire logic        i_rst,
  input  wire logic        i_valid,
  input  wire logic [31:0] i_a,
  input  wire logic [31:0] i_b,
  input  wire logic [31:0] i_c,
  input  wire apb_req_t    i_apb,
  output logic      [31:0] o_prdata,
  output logic             o_valid,
  output logic      [31:0] o_result,
  output fp_flags_t        o_flags
);

  fma_op_e  op;
  logic     s1_valid;
  unpack_t  s1_stage;
  logic     s3_valid;
  aligned_t s3_stage;
  logic     s5_valid;
  norm_t    s5_stage;

  // Register block, sees every result flag
  fma_csr u_csr (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_apb       (i_apb),
    .i_res_valid (o_valid),
    .i_res_flags (o_flags),
    .o_prdata    (o_prdata),
    .o_op        (op)
  );

  // ==========================================================
  // Six-stage datapath
  // ==========================================================
  fma_unpack u_unpack (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_a     (i_a),
    .i_b     (i_b),
    .i_c     (i_c),
    .i_op    (op),
    .o_valid (s1_valid),
    .o_stage (s1_stage)
  );

  fma_mul_align u_mul_align (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (s1_valid),
    .i_stage (s1_stage),
    .o_valid (s3_valid),
    .o_stage (s3_stage)
  );

  fma_add_norm u_add_norm (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (s3_valid),
    .i_stage (s3_stage),
    .o_valid (s5_valid),
    .o_stage (s5_stage)
  );

  fma_round_pack u_round_pack (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_valid  (s5_valid),
    .i_stage  (s5_stage),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_flags  (o_flags)
  );

endmodule

`default_nettype wire

//--- fma_round_pack.sv
// ==========================================================
// FMA stage 6, round and pack
// ==========================================================
`default_nettype none
`include "fma_defs.svh"

module fma_round_pack
  import fma_pkg::*;
(
  input  wire logic  i_clk,
  input  wire logic  i_rst,
  input  wire logic  i_valid,
  input  wire norm_t i_stage,
  output logic       o_valid,
  output fp32_u      o_result,
  output fp_flags_t  o_flags
);

  // Largest biased exponent of a finite number
  localparam logic signed [9:0] exp_top = 10'(2 * `FMA_BIAS);

  logic                          round_up;
  logic                          inexact;
  logic [`FMA_MANT_BITS:0]       mant_r;
  logic signed [9:0]             exp_r;
  fp32_u                         result_d;
  fp_flags_t                     flags_d;

  // Round to nearest, ties to even
  assign round_up = i_stage.guard & (i_stage.round | i_stage.sticky | i_stage.mant[0]);
  assign inexact  = i_stage.guard | i_stage.round | i_stage.sticky;
  assign mant_r   = {1'b0, i_stage.mant} + (`FMA_MANT_BITS+1)'(round_up);
  // Carry out leaves 1.000..0, so only the exponent moves
  assign exp_r    = i_stage.exp + 10'(mant_r[`FMA_MANT_BITS]);

  always_comb begin
    result_d = '0;
    flags_d  = '0;
    if (i_stage.is_special) begin
      // NaN and infinity results bypass rounding
      result_d   = i_stage.special_res;
      flags_d.nv = i_stage.special_nv;
    end else if (i_stage.zero) begin
      result_d.f.sign = i_stage.sign;
    end else if (exp_r > exp_top) begin
      // Overflow to signed infinity
      result_d.f = {i_stage.sign, 8'hFF, 23'd0};
      flags_d.of = 1'b1;
      flags_d.nx = 1'b1;
    end else if (exp_r < 10'sd1) begin
      // Below the normal range, flush to signed zero
      result_d.f.sign = i_stage.sign;
      flags_d.uf      = 1'b1;
      flags_d.nx      = 1'b1;
    end else begin
      result_d.f = {i_stage.sign, exp_r[7:0], mant_r[`FMA_FRAC_BITS-1:0]};
      flags_d.nx = inexact;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_result <= result_d;
      o_flags  <= flags_d;
    end
  end

endmodule

`default_nettype wire

//--- fma_add_norm.sv
// ==========================================================
// FMA stages 4 and 5, add and normalize
// ==========================================================
`default_nettype none
`include "fma_defs.svh"

module fma_add_norm
  import fma_pkg::*;
(
  input  wire logic     i_clk,
  input  wire logic     i_rst,
  input  wire logic     i_valid,
  input  wire aligned_t i_stage,
  output logic          o_valid,
  output norm_t         o_stage
);

  logic [`FMA_SUM_BITS-1:0] sum_d;
  logic                     sign_d;
  logic [5:0]               lz_d;
  logic                     s4_valid;
  aligned_t                 s4_stage;
  logic [`FMA_SUM_BITS-1:0] s4_sum;
  logic                     s4_sign;
  logic [5:0]               s4_lz;
  logic [`FMA_SUM_BITS-1:0] norm_sum;
  norm_t                    stage_d;

  // ==========================================================
  // Stage 4, signed magnitude add and leading-zero count
  // ==========================================================
  always_comb begin
    if (i_stage.prod_sign == i_stage.c_sign) begin
      sum_d  = i_stage.prod_win + i_stage.add_win;
      sign_d = i_stage.prod_sign;
    end else if (i_stage.prod_win > i_stage.add_win) begin
      sum_d  = i_stage.prod_win - i_stage.add_win;
      sign_d = i_stage.prod_sign;
    end else if (i_stage.add_win > i_stage.prod_win) begin
      sum_d  = i_stage.add_win - i_stage.prod_win;
      sign_d = i_stage.c_sign;
    end else begin
      // Exact cancellation is +0
      sum_d  = '0;
      sign_d = 1'b0;
    end
    // Highest set bit wins, all zero counts the full window
    lz_d = 6'(`FMA_SUM_BITS);
    for (int i = 0; i < `FMA_SUM_BITS; i++) begin
      if (sum_d[i]) begin
        lz_d = 6'(`FMA_SUM_BITS - 1 - i);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s4_valid <= 1'b0;
    end else begin
      s4_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      s4_stage <= i_stage;
      s4_sum   <= sum_d;
      s4_sign  <= sign_d;
      s4_lz    <= lz_d;
    end
  end

  // ==========================================================
  // Stage 5, move the leading one to window bit 48
  // ==========================================================
  // Carry out shifts right by one, otherwise left by lz - 1
  assign norm_sum = (s4_lz == 6'd0) ? (s4_sum >> 1) : (s4_sum << (s4_lz - 6'd1));

  always_comb begin
    stage_d             = '0;
    stage_d.mant        = norm_sum[`FMA_SUM_BITS-2 -: `FMA_MANT_BITS];
    stage_d.guard       = norm_sum[`FMA_SUM_BITS-`FMA_MANT_BITS-2];
    stage_d.round       = norm_sum[`FMA_SUM_BITS-`FMA_MANT_BITS-3];
    // Bit lost on the right shift and alignment sticky join the low bits
    stage_d.sticky      = (|norm_sum[`FMA_SUM_BITS-`FMA_MANT_BITS-4:0])
                          | ((s4_lz == 6'd0) & s4_sum[0]) | s4_stage.sticky;
    stage_d.sign        = s4_sign;
    stage_d.exp         = s4_stage.exp - 10'(s4_lz) + 10'sd1;
    stage_d.zero        = (s4_lz == 6'(`FMA_SUM_BITS));
    stage_d.is_special  = s4_stage.is_special;
    stage_d.special_res = s4_stage.special_res;
    stage_d.special_nv  = s4_stage.special_nv;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= s4_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s4_valid) begin
      o_stage <= stage_d;
    end
  end

endmodule

`default_nettype wire

//--- fma_mul_align.sv
// ==========================================================
// FMA stages 2 and 3, multiply and align
// ==========================================================
`default_nettype none
`include "fma_defs.svh"

module fma_mul_align
  import fma_pkg::*;
(
  input  wire logic    i_clk,
  input  wire logic    i_rst,
  input  wire logic    i_valid,
  input  wire unpack_t i_stage,
  output logic         o_valid,
  output aligned_t     o_stage
);

  // Right shift with shifted-out bits jammed into window bit 0
  // Returns {shifted window, sticky}
  function automatic logic [`FMA_SUM_BITS:0] shift_jam(
    input logic [`FMA_SUM_BITS-1:0] v,
    input logic [5:0]               sh
  );
    logic sticky;
    sticky    = |(v & ~({`FMA_SUM_BITS{1'b1}} << sh));
    shift_jam = {(v >> sh) | {{(`FMA_SUM_BITS-1){1'b0}}, sticky}, sticky};
  endfunction

  logic                          s2_valid;
  unpack_t                       s2_stage;
  logic [`FMA_PROD_BITS-1:0]     s2_prod;
  logic [`FMA_SUM_BITS-1:0]      prod_win;
  logic [`FMA_SUM_BITS-1:0]      add_win;
  logic signed [9:0]             exp_diff;
  logic [9:0]                    diff_mag;
  logic [5:0]                    shamt;
  logic [`FMA_SUM_BITS:0]        prod_sh;
  logic [`FMA_SUM_BITS:0]        add_sh;
  aligned_t                      stage_d;

  // ==========================================================
  // Stage 2, mantissa product
  // ==========================================================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      s2_stage <= i_stage;
      s2_prod  <= i_stage.mant_a * i_stage.mant_b;
    end
  end

  // ==========================================================
  // Stage 3, alignment
  // ==========================================================
  // Window bit 48 carries the exponent for both operands
  assign prod_win = {1'b0, s2_prod, 1'b0};
  assign add_win  = {1'b0, s2_stage.c_mant, {(`FMA_SUM_BITS-`FMA_MANT_BITS-1){1'b0}}};

  assign exp_diff = s2_stage.prod_exp - s2_stage.c_exp;
  assign diff_mag = exp_diff[9] ? 10'(-exp_diff) : 10'(exp_diff);
  // Saturate at the window width
  assign shamt    = (diff_mag > 10'(`FMA_SUM_BITS)) ? 6'(`FMA_SUM_BITS) : diff_mag[5:0];
  assign prod_sh  = shift_jam(prod_win, shamt);
  assign add_sh   = shift_jam(add_win, shamt);

  always_comb begin
    stage_d             = '0;
    stage_d.prod_sign   = s2_stage.prod_sign;
    stage_d.c_sign      = s2_stage.c_sign;
    stage_d.is_special  = s2_stage.is_special;
    stage_d.special_res = s2_stage.special_res;
    stage_d.special_nv  = s2_stage.special_nv;
    stage_d.prod_win    = prod_win;
    stage_d.add_win     = add_win;
    if (s2_prod == '0) begin
      // Zero product, addend passes unshifted
      stage_d.exp = s2_stage.c_exp;
    end else if (s2_stage.c_zero || !exp_diff[9]) begin
      // Product exponent wins, addend moves right
      stage_d.exp     = s2_stage.prod_exp;
      stage_d.add_win = add_sh[`FMA_SUM_BITS:1];
      stage_d.sticky  = add_sh[0];
    end else begin
      stage_d.exp      = s2_stage.c_exp;
      stage_d.prod_win = prod_sh[`FMA_SUM_BITS:1];
      stage_d.sticky   = prod_sh[0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= s2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (s2_valid) begin
      o_stage <= stage_d;
    end
  end

endmodule

`default_nettype wire

//--- fma_unpack.sv
// ==========================================================
// FMA stage 1, unpack and special cases
// ==========================================================
`default_nettype none
`include "fma_defs.svh"

module fma_unpack
  import fma_pkg::*;
(
  input  wire logic    i_clk,
  input  wire logic    i_rst,
  input  wire logic    i_valid,
  input  wire fp32_u   i_a,
  input  wire fp32_u   i_b,
  input  wire fp32_u   i_c,
  input  wire fma_op_e i_op,
  output logic         o_valid,
  output unpack_t      o_stage
);

  // Class bits {zero, inf, nan, snan}, subnormals count as zero
  function automatic logic [3:0] classify(input fp32_u v);
    logic exp_ones;
    logic frac_zero;
    exp_ones  = &v.f.exp;
    frac_zero = (v.f.frac == '0);
    classify  = {(v.f.exp == '0), exp_ones & frac_zero, exp_ones & ~frac_zero,
                 exp_ones & ~frac_zero & ~v.f.frac[`FMA_FRAC_BITS-1]};
  endfunction

  logic [3:0] cls_a;
  logic [3:0] cls_b;
  logic [3:0] cls_c;
  logic       sign_p;
  logic       sign_c;
  unpack_t    stage_d;

  assign cls_a = classify(i_a);
  assign cls_b = classify(i_b);
  assign cls_c = classify(i_c);

  // Variant signs
  assign sign_p = i_a.f.sign ^ i_b.f.sign ^ i_op[1];
  assign sign_c = i_c.f.sign ^ i_op[0];

  always_comb begin
    stage_d           = '0;
    // Zero or subnormal operand gets an all-zero mantissa
    stage_d.mant_a    = cls_a[3] ? '0 : {1'b1, i_a.f.frac};
    stage_d.mant_b    = cls_b[3] ? '0 : {1'b1, i_b.f.frac};
    stage_d.prod_sign = sign_p;
    // Biased exponent of product bit 47, one above ea + eb - bias
    stage_d.prod_exp  = 10'({2'b00, i_a.f.exp}) + 10'({2'b00, i_b.f.exp})
                        - 10'(`FMA_BIAS - 1);
    stage_d.c_sign    = sign_c;
    stage_d.c_exp     = 10'({2'b00, i_c.f.exp});
    stage_d.c_mant    = cls_c[3] ? '0 : {1'b1, i_c.f.frac};
    stage_d.c_zero    = cls_c[3];

    // Priority: NaN, inf x 0, opposite infinities, plain infinity
    if (cls_a[1] | cls_b[1] | cls_c[1]) begin
      stage_d.is_special       = 1'b1;
      stage_d.special_res.bits = `FMA_CANON_NAN;
      stage_d.special_nv       = cls_a[0] | cls_b[0] | cls_c[0];
    end else if ((cls_a[2] & cls_b[3]) | (cls_a[3] & cls_b[2])) begin
      stage_d.is_special       = 1'b1;
      stage_d.special_res.bits = `FMA_CANON_NAN;
      stage_d.special_nv       = 1'b1;
    end else if (cls_a[2] | cls_b[2]) begin
      stage_d.is_special = 1'b1;
      if (cls_c[2] & (sign_c != sign_p)) begin
        stage_d.special_res.bits = `FMA_CANON_NAN;
        stage_d.special_nv       = 1'b1;
      end else begin
        stage_d.special_res.f = {sign_p, 8'hFF, 23'd0};
      end
    end else if (cls_c[2]) begin
      stage_d.is_special    = 1'b1;
      stage_d.special_res.f = {sign_c, 8'hFF, 23'd0};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_stage <= stage_d;
    end
  end

endmodule

`default_nettype wire

//--- fma_csr.sv
// ==========================================================
// FMA control and status registers
// ==========================================================
`default_nettype none
`include "fma_defs.svh"

module fma_csr
  import fma_pkg::*;
(
  input  wire logic        i_clk,
  input  wire logic        i_rst,
  input  wire apb_req_t    i_apb,
  input  wire logic        i_res_valid,
  input  wire fp_flags_t   i_res_flags,
  output logic      [31:0] o_prdata,
  output fma_op_e          o_op
);

  logic      wr_en;
  logic      wr_ctrl;
  logic      wr_flags;
  fp_flags_t flags_q;
  fp_flags_t clr_mask;
  fp_flags_t set_mask;

  // Access phase completes in the same cycle, no wait states
  assign wr_en    = i_apb.psel & i_apb.penable & i_apb.pwrite;
  assign wr_ctrl  = wr_en & (i_apb.paddr == `FMA_ADDR_CTRL);
  assign wr_flags = wr_en & (i_apb.paddr == `FMA_ADDR_FLAGS);

  // Write one to clear
  assign clr_mask = wr_flags ? fp_flags_t'(i_apb.pwdata[3:0]) : '0;
  // Flags of each finished result
  assign set_mask = i_res_valid ? i_res_flags : '0;

  // ==========================================================
  // Registers
  // ==========================================================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_op <= FMADD;
    end else if (wr_ctrl) begin
      // Applies to operands from the next cycle on
      o_op <= fma_op_e'(i_apb.pwdata[1:0]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      flags_q <= '0;
    end else begin
      // New flag wins over a clear in the same cycle
      flags_q <= (flags_q & ~clr_mask) | set_mask;
    end
  end

  // Read mux, unmapped addresses return zero
  always_comb begin
    case (i_apb.paddr)
      `FMA_ADDR_CTRL:  o_prdata = {30'd0, o_op};
      `FMA_ADDR_FLAGS: o_prdata = {28'd0, flags_q};
      default:         o_prdata = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- fma_pkg.sv
// ==========================================================
// FMA datapath types
// ==========================================================
`default_nettype none
`include "fma_defs.svh"

package fma_pkg;

  // IEEE 754 single word, raw or split into fields
  typedef struct packed {
    logic                      sign;
    logic [`FMA_EXP_BITS-1:0]  exp;
    logic [`FMA_FRAC_BITS-1:0] frac;
  } fp32_fields_t;

  typedef union packed {
    logic [31:0]  bits;
    fp32_fields_t f;
  } fp32_u;

  // Bit 0 negates the addend, bit 1 negates the product
  typedef enum logic [1:0] {
    FMADD  = 2'b00,
    FMSUB  = 2'b01,
    FNMSUB = 2'b10,
    FNMADD = 2'b11
  } fma_op_e;

  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // Stage 1 output
  typedef struct packed {
    logic [`FMA_MANT_BITS-1:0]           mant_a;
    logic [`FMA_MANT_BITS-1:0]           mant_b;
    logic                                prod_sign;
    logic signed [`FMA_EXP_EXT_BITS-1:0] prod_exp;
    logic                                c_sign;
    logic signed [`FMA_EXP_EXT_BITS-1:0] c_exp;
    logic [`FMA_MANT_BITS-1:0]           c_mant;
    logic                                c_zero;
    logic                                is_special;
    fp32_u                               special_res;
    logic                                special_nv;
  } unpack_t;

  // Stage 3 output, both operands placed in the adder window
  typedef struct packed {
    logic [`FMA_SUM_BITS-1:0]            prod_win;
    logic [`FMA_SUM_BITS-1:0]            add_win;
    logic                                prod_sign;
    logic                                c_sign;
    logic signed [`FMA_EXP_EXT_BITS-1:0] exp;
    logic                                sticky;
    logic                                is_special;
    fp32_u                               special_res;
    logic                                special_nv;
  } aligned_t;

  // Stage 5 output, ready for rounding
  typedef struct packed {
    logic [`FMA_MANT_BITS-1:0]           mant;
    logic                                guard;
    logic                                round;
    logic                                sticky;
    logic                                sign;
    logic signed [`FMA_EXP_EXT_BITS-1:0] exp;
    logic                                zero;
    logic                                is_special;
    fp32_u                               special_res;
    logic                                special_nv;
  } norm_t;

endpackage

`default_nettype wire

//--- fma_defs.svh
// ==========================================================
// FMA shared constants
// ==========================================================
`ifndef FMA_DEFS_SVH
`define FMA_DEFS_SVH

// Single-precision field widths
`define FMA_EXP_BITS     8
`define FMA_FRAC_BITS    23
`define FMA_MANT_BITS    24
// Full 24x24 product
`define FMA_PROD_BITS    48
// Adder window, carry bit + product + guard position
`define FMA_SUM_BITS     50
// Signed working exponent
`define FMA_EXP_EXT_BITS 10
`define FMA_BIAS         127
// Quiet canonical NaN
`define FMA_CANON_NAN    32'h7FC0_0000
// Input edge to o_valid, one register per stage
`define FMA_LATENCY      6
// APB byte addresses
`define FMA_ADDR_CTRL    4'h0
`define FMA_ADDR_FLAGS   4'h4

`endif
